/* all.f */
+incdir+src
src/axil_pkg.sv
src/axil_skid.sv
src/axil_skid_bridge.sv
src/axil_cmd_master.sv
src/axil_reg_slave.sv
src/axil_subsys_top.sv
tb/tb_clk_gen.sv
tb/axil_subsys_checker.sv
tb/axil_subsys_tb.sv

/* src/axil_cmd_master.sv */
`timescale 1ns/100ps

module axil_cmd_master (
    input  logic               clk,
    input  logic               arst_n,

    input  logic               cmd_valid,
    output logic               cmd_ready,
    input  axil_pkg::cmd_t     cmd,

    output logic               rsp_valid,
    input  logic               rsp_ready,
    output axil_pkg::rsp_t     rsp,

    output axil_pkg::aw_chan_t aw,
    output logic               aw_valid,
    input  logic               aw_ready,
    output axil_pkg::w_chan_t  w,
    output logic               w_valid,
    input  logic               w_ready,
    input  axil_pkg::b_chan_t  b,
    input  logic               b_valid,
    output logic               b_ready,
    output axil_pkg::ar_chan_t ar,
    output logic               ar_valid,
    input  logic               ar_ready,
    input  axil_pkg::r_chan_t  r,
    input  logic               r_valid,
    output logic               r_ready
);

    axil_pkg::master_state_e state;
    axil_pkg::cmd_t          cmd_q;
    axil_pkg::rsp_t          rsp_q;
    logic                    aw_done;
    logic                    w_done;
    logic                    aw_fire;
    logic                    w_fire;
    logic                    b_fire;
    logic                    r_fire;

    assign aw_fire = aw_valid && aw_ready;
    assign w_fire  = w_valid && w_ready;
    assign b_fire  = b_valid && b_ready;
    assign r_fire  = r_valid && r_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= axil_pkg::M_IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            case (state)
                axil_pkg::M_IDLE: begin
                    if (cmd_valid) state <= cmd.write ? axil_pkg::M_WRITE : axil_pkg::M_READ;
                end
                axil_pkg::M_WRITE: begin
                    // address and data may complete in different cycles
                    if ((aw_done || aw_fire) && (w_done || w_fire)) begin
                        state   <= axil_pkg::M_WAIT_B;
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                    end else begin
                        if (aw_fire) aw_done <= 1'b1;
                        if (w_fire) w_done <= 1'b1;
                    end
                end
                axil_pkg::M_WAIT_B: if (b_fire) state <= axil_pkg::M_RESP;
                axil_pkg::M_READ:   if (ar_ready) state <= axil_pkg::M_WAIT_R;
                axil_pkg::M_WAIT_R: if (r_fire) state <= axil_pkg::M_RESP;
                axil_pkg::M_RESP:   if (rsp_ready) state <= axil_pkg::M_IDLE;
                default:            state <= axil_pkg::M_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) cmd_q <= cmd;
        if (b_fire) rsp_q <= '{write: 1'b1, data: '0, resp: b.resp}; // writes report no data
        if (r_fire) rsp_q <= '{write: 1'b0, data: r.data, resp: r.resp};
    end

    assign cmd_ready = (state == axil_pkg::M_IDLE);
    assign rsp_valid = (state == axil_pkg::M_RESP);
    assign rsp       = rsp_q;

    assign aw_valid = (state == axil_pkg::M_WRITE) && !aw_done;
    assign aw.addr  = cmd_q.addr;
    assign w_valid  = (state == axil_pkg::M_WRITE) && !w_done;
    assign w.data   = cmd_q.data;
    assign w.strb   = cmd_q.strb;
    assign b_ready  = (state == axil_pkg::M_WAIT_B);

    assign ar_valid = (state == axil_pkg::M_READ);
    assign ar.addr  = cmd_q.addr;
    assign r_ready  = (state == axil_pkg::M_WAIT_R);

endmodule

/* src/axil_defs.svh */
`ifndef AXIL_DEFS_SVH
`define AXIL_DEFS_SVH

// bus widths shared by every block on the AXI-Lite path
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32

// number of 32-bit words in the register bank
`define AXIL_NUM_REGS 16

`endif

/* src/axil_pkg.sv */
`include "axil_defs.svh"

package axil_pkg;

    typedef logic [`AXIL_ADDR_W-1:0]   addr_t;
    typedef logic [`AXIL_DATA_W-1:0]   data_t;
    typedef logic [`AXIL_DATA_W/8-1:0] strb_t;
    typedef logic [1:0]                resp_t;

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_SLVERR = 2'd2;

    typedef struct packed {
        addr_t addr;
    } aw_chan_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } w_chan_t;

    typedef struct packed {
        resp_t resp;
    } b_chan_t;

    typedef struct packed {
        addr_t addr;
    } ar_chan_t;

    typedef struct packed {
        data_t data;
        resp_t resp;
    } r_chan_t;

    // command from the outside world where strb only matters for writes
    typedef struct packed {
        logic  write;
        addr_t addr;
        data_t data;
        strb_t strb;
    } cmd_t;

    typedef struct packed {
        logic  write;
        data_t data;
        resp_t resp;
    } rsp_t;

    typedef enum logic [2:0] {M_IDLE, M_WRITE, M_WAIT_B, M_READ, M_WAIT_R, M_RESP} master_state_e;

    typedef enum logic {S_ACCEPT, S_RESP} slave_state_e;

endpackage

/* src/axil_reg_slave.sv */
`timescale 1ns/100ps
`include "axil_defs.svh"

module axil_reg_slave (
    input  logic               clk,
    input  logic               arst_n,

    input  axil_pkg::aw_chan_t aw,
    input  logic               aw_valid,
    output logic               aw_ready,
    input  axil_pkg::w_chan_t  w,
    input  logic               w_valid,
    output logic               w_ready,
    output axil_pkg::b_chan_t  b,
    output logic               b_valid,
    input  logic               b_ready,
    input  axil_pkg::ar_chan_t ar,
    input  logic               ar_valid,
    output logic               ar_ready,
    output axil_pkg::r_chan_t  r,
    output logic               r_valid,
    input  logic               r_ready
);

    localparam int IDX_W  = $clog2(`AXIL_NUM_REGS);
    localparam int STRB_W = `AXIL_DATA_W / 8;

    axil_pkg::slave_state_e wr_state;
    axil_pkg::slave_state_e rd_state;
    axil_pkg::data_t        regs [`AXIL_NUM_REGS];
    axil_pkg::aw_chan_t     aw_q;
    axil_pkg::w_chan_t      w_q;
    axil_pkg::b_chan_t      b_q;
    axil_pkg::r_chan_t      r_q;
    logic                   aw_taken;
    logic                   w_taken;
    logic                   aw_fire;
    logic                   w_fire;
    logic                   ar_fire;
    logic                   wr_go;
    axil_pkg::addr_t        wr_addr;
    axil_pkg::w_chan_t      wr_beat;

    function automatic logic in_range(input axil_pkg::addr_t addr);
        return addr < axil_pkg::addr_t'(4 * `AXIL_NUM_REGS);
    endfunction

    assign aw_fire = aw_valid && aw_ready;
    assign w_fire  = w_valid && w_ready;
    assign ar_fire = ar_valid && ar_ready;

    // the write goes ahead in the cycle its second half arrives
    assign wr_go   = (aw_taken || aw_fire) && (w_taken || w_fire);
    assign wr_addr = aw_taken ? aw_q.addr : aw.addr;
    assign wr_beat = w_taken ? w_q : w;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_state <= axil_pkg::S_ACCEPT;
            aw_taken <= 1'b0;
            w_taken  <= 1'b0;
            rd_state <= axil_pkg::S_ACCEPT;
        end else begin
            if (wr_state == axil_pkg::S_ACCEPT) begin
                if (wr_go) begin
                    wr_state <= axil_pkg::S_RESP;
                    aw_taken <= 1'b0;
                    w_taken  <= 1'b0;
                end else begin
                    if (aw_fire) aw_taken <= 1'b1;
                    if (w_fire) w_taken <= 1'b1;
                end
            end else if (b_ready) begin
                wr_state <= axil_pkg::S_ACCEPT;
            end
            if (ar_fire) rd_state <= axil_pkg::S_RESP;
            else if (r_valid && r_ready) rd_state <= axil_pkg::S_ACCEPT;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `AXIL_NUM_REGS; i++) regs[i] <= '0;
        end else if (wr_go && in_range(wr_addr)) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (wr_beat.strb[i]) regs[wr_addr[IDX_W+1:2]][8*i +: 8] <= wr_beat.data[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) aw_q <= aw;
        if (w_fire) w_q <= w;
        if (wr_go) b_q.resp <= in_range(wr_addr) ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
        if (ar_fire) begin
            r_q.data <= in_range(ar.addr) ? regs[ar.addr[IDX_W+1:2]] : '0; // out of bank reads zero
            r_q.resp <= in_range(ar.addr) ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
        end
    end

    assign aw_ready = (wr_state == axil_pkg::S_ACCEPT) && !aw_taken;
    assign w_ready  = (wr_state == axil_pkg::S_ACCEPT) && !w_taken;
    assign b_valid  = (wr_state == axil_pkg::S_RESP);
    assign b        = b_q;

    assign ar_ready = (rd_state == axil_pkg::S_ACCEPT);
    assign r_valid  = (rd_state == axil_pkg::S_RESP);
    assign r        = r_q;

endmodule

/* src/axil_skid.sv */
`timescale 1ns/100ps

module axil_skid #(
    parameter type chan_t = logic
) (
    input  logic  clk,
    input  logic  arst_n,

    input  chan_t slv_data,
    input  logic  slv_valid,
    output logic  slv_ready,

    output chan_t mst_data,
    output logic  mst_valid,
    input  logic  mst_ready
);

    logic  out_valid;
    logic  in_ready; // low exactly when the spare entry holds an item
    chan_t out_data;
    chan_t spare_data;
    logic  in_fire;
    logic  out_free;

    assign in_fire  = slv_valid && in_ready;
    assign out_free = !out_valid || mst_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            in_ready  <= 1'b1;
        end else if (out_free) begin
            if (!in_ready) begin
                out_valid <= 1'b1; // spare moves up before any new input
                in_ready  <= 1'b1;
            end else begin
                out_valid <= slv_valid;
            end
        end else if (in_fire) begin
            in_ready <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            if (!in_ready) out_data <= spare_data;
            else if (slv_valid) out_data <= slv_data;
        end else if (in_fire) begin
            spare_data <= slv_data; // output is stalled so park it
        end
    end

    assign slv_ready = in_ready;
    assign mst_valid = out_valid;
    assign mst_data  = out_data;

endmodule

/* src/axil_skid_bridge.sv */
`timescale 1ns/100ps

module axil_skid_bridge #(
    parameter bit BYPASS_AW = 1'b0,
    parameter bit BYPASS_W  = 1'b0,
    parameter bit BYPASS_B  = 1'b0,
    parameter bit BYPASS_AR = 1'b0,
    parameter bit BYPASS_R  = 1'b0
) (
    input  logic               clk,
    input  logic               arst_n,

    input  axil_pkg::aw_chan_t slv_aw,
    input  logic               slv_aw_valid,
    output logic               slv_aw_ready,
    input  axil_pkg::w_chan_t  slv_w,
    input  logic               slv_w_valid,
    output logic               slv_w_ready,
    output axil_pkg::b_chan_t  slv_b,
    output logic               slv_b_valid,
    input  logic               slv_b_ready,
    input  axil_pkg::ar_chan_t slv_ar,
    input  logic               slv_ar_valid,
    output logic               slv_ar_ready,
    output axil_pkg::r_chan_t  slv_r,
    output logic               slv_r_valid,
    input  logic               slv_r_ready,

    output axil_pkg::aw_chan_t mst_aw,
    output logic               mst_aw_valid,
    input  logic               mst_aw_ready,
    output axil_pkg::w_chan_t  mst_w,
    output logic               mst_w_valid,
    input  logic               mst_w_ready,
    input  axil_pkg::b_chan_t  mst_b,
    input  logic               mst_b_valid,
    output logic               mst_b_ready,
    output axil_pkg::ar_chan_t mst_ar,
    output logic               mst_ar_valid,
    input  logic               mst_ar_ready,
    input  axil_pkg::r_chan_t  mst_r,
    input  logic               mst_r_valid,
    output logic               mst_r_ready
);

    if (BYPASS_AW) begin : g_aw_wire
        assign mst_aw       = slv_aw;
        assign mst_aw_valid = slv_aw_valid;
        assign slv_aw_ready = mst_aw_ready;
    end else begin : g_aw_skid
        axil_skid #(.chan_t(axil_pkg::aw_chan_t)) u_skid (
            .clk, .arst_n,
            .slv_data (slv_aw), .slv_valid (slv_aw_valid), .slv_ready (slv_aw_ready),
            .mst_data (mst_aw), .mst_valid (mst_aw_valid), .mst_ready (mst_aw_ready)
        );
    end

    if (BYPASS_W) begin : g_w_wire
        assign mst_w       = slv_w;
        assign mst_w_valid = slv_w_valid;
        assign slv_w_ready = mst_w_ready;
    end else begin : g_w_skid
        axil_skid #(.chan_t(axil_pkg::w_chan_t)) u_skid (
            .clk, .arst_n,
            .slv_data (slv_w), .slv_valid (slv_w_valid), .slv_ready (slv_w_ready),
            .mst_data (mst_w), .mst_valid (mst_w_valid), .mst_ready (mst_w_ready)
        );
    end

    // responses flow from the master side back to the slave side
    if (BYPASS_B) begin : g_b_wire
        assign slv_b       = mst_b;
        assign slv_b_valid = mst_b_valid;
        assign mst_b_ready = slv_b_ready;
    end else begin : g_b_skid
        axil_skid #(.chan_t(axil_pkg::b_chan_t)) u_skid (
            .clk, .arst_n,
            .slv_data (mst_b), .slv_valid (mst_b_valid), .slv_ready (mst_b_ready),
            .mst_data (slv_b), .mst_valid (slv_b_valid), .mst_ready (slv_b_ready)
        );
    end

    if (BYPASS_AR) begin : g_ar_wire
        assign mst_ar       = slv_ar;
        assign mst_ar_valid = slv_ar_valid;
        assign slv_ar_ready = mst_ar_ready;
    end else begin : g_ar_skid
        axil_skid #(.chan_t(axil_pkg::ar_chan_t)) u_skid (
            .clk, .arst_n,
            .slv_data (slv_ar), .slv_valid (slv_ar_valid), .slv_ready (slv_ar_ready),
            .mst_data (mst_ar), .mst_valid (mst_ar_valid), .mst_ready (mst_ar_ready)
        );
    end

    if (BYPASS_R) begin : g_r_wire
        assign slv_r       = mst_r;
        assign slv_r_valid = mst_r_valid;
        assign mst_r_ready = slv_r_ready;
    end else begin : g_r_skid
        axil_skid #(.chan_t(axil_pkg::r_chan_t)) u_skid (
            .clk, .arst_n,
            .slv_data (mst_r), .slv_valid (mst_r_valid), .slv_ready (mst_r_ready),
            .mst_data (slv_r), .mst_valid (slv_r_valid), .mst_ready (slv_r_ready)
        );
    end

endmodule

/* src/axil_subsys_top.sv */
`timescale 1ns/100ps

module axil_subsys_top #(
    parameter bit BYPASS_AW = 1'b0,
    parameter bit BYPASS_W  = 1'b0,
    parameter bit BYPASS_B  = 1'b0,
    parameter bit BYPASS_AR = 1'b0,
    parameter bit BYPASS_R  = 1'b0
) (
    input  logic           clk,
    input  logic           arst_n,

    input  logic           cmd_valid,
    output logic           cmd_ready,
    input  axil_pkg::cmd_t cmd,

    output logic           rsp_valid,
    input  logic           rsp_ready,
    output axil_pkg::rsp_t rsp
);

    // m_ nets sit between producer and bridge, s_ nets between bridge and bank
    axil_pkg::aw_chan_t m_aw, s_aw;
    axil_pkg::w_chan_t  m_w, s_w;
    axil_pkg::b_chan_t  m_b, s_b;
    axil_pkg::ar_chan_t m_ar, s_ar;
    axil_pkg::r_chan_t  m_r, s_r;
    logic m_aw_valid, m_aw_ready, m_w_valid, m_w_ready, m_b_valid, m_b_ready;
    logic m_ar_valid, m_ar_ready, m_r_valid, m_r_ready;
    logic s_aw_valid, s_aw_ready, s_w_valid, s_w_ready, s_b_valid, s_b_ready;
    logic s_ar_valid, s_ar_ready, s_r_valid, s_r_ready;

    axil_cmd_master u_master (
        .clk, .arst_n, .cmd_valid, .cmd_ready, .cmd, .rsp_valid, .rsp_ready, .rsp,
        .aw (m_aw), .aw_valid (m_aw_valid), .aw_ready (m_aw_ready),
        .w  (m_w),  .w_valid  (m_w_valid),  .w_ready  (m_w_ready),
        .b  (m_b),  .b_valid  (m_b_valid),  .b_ready  (m_b_ready),
        .ar (m_ar), .ar_valid (m_ar_valid), .ar_ready (m_ar_ready),
        .r  (m_r),  .r_valid  (m_r_valid),  .r_ready  (m_r_ready)
    );

    axil_skid_bridge #(
        .BYPASS_AW (BYPASS_AW), .BYPASS_W (BYPASS_W), .BYPASS_B (BYPASS_B),
        .BYPASS_AR (BYPASS_AR), .BYPASS_R (BYPASS_R)
    ) u_bridge (
        .clk, .arst_n,
        .slv_aw (m_aw), .slv_aw_valid (m_aw_valid), .slv_aw_ready (m_aw_ready),
        .slv_w  (m_w),  .slv_w_valid  (m_w_valid),  .slv_w_ready  (m_w_ready),
        .slv_b  (m_b),  .slv_b_valid  (m_b_valid),  .slv_b_ready  (m_b_ready),
        .slv_ar (m_ar), .slv_ar_valid (m_ar_valid), .slv_ar_ready (m_ar_ready),
        .slv_r  (m_r),  .slv_r_valid  (m_r_valid),  .slv_r_ready  (m_r_ready),
        .mst_aw (s_aw), .mst_aw_valid (s_aw_valid), .mst_aw_ready (s_aw_ready),
        .mst_w  (s_w),  .mst_w_valid  (s_w_valid),  .mst_w_ready  (s_w_ready),
        .mst_b  (s_b),  .mst_b_valid  (s_b_valid),  .mst_b_ready  (s_b_ready),
        .mst_ar (s_ar), .mst_ar_valid (s_ar_valid), .mst_ar_ready (s_ar_ready),
        .mst_r  (s_r),  .mst_r_valid  (s_r_valid),  .mst_r_ready  (s_r_ready)
    );

    axil_reg_slave u_regs (
        .clk, .arst_n,
        .aw (s_aw), .aw_valid (s_aw_valid), .aw_ready (s_aw_ready),
        .w  (s_w),  .w_valid  (s_w_valid),  .w_ready  (s_w_ready),
        .b  (s_b),  .b_valid  (s_b_valid),  .b_ready  (s_b_ready),
        .ar (s_ar), .ar_valid (s_ar_valid), .ar_ready (s_ar_ready),
        .r  (s_r),  .r_valid  (s_r_valid),  .r_ready  (s_r_ready)
    );

endmodule

/* tb/axil_subsys_checker.sv */
`timescale 1ns/100ps
`include "axil_defs.svh"

module axil_subsys_checker (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           cmd_valid,
    input  logic           cmd_ready,
    input  axil_pkg::cmd_t cmd,
    input  logic           rsp_valid,
    input  logic           rsp_ready,
    input  axil_pkg::rsp_t rsp,
    output int             passes,
    output int             fails,
    output int             pending
);

    axil_pkg::cmd_t  sent [$]; // commands whose response is still due
    axil_pkg::data_t shadow [`AXIL_NUM_REGS];
    logic            idle_checked;

    // works out the bank's answer from the shadow copy
    function automatic axil_pkg::rsp_t expected_rsp(input axil_pkg::cmd_t c);
        axil_pkg::rsp_t e;
        logic           hit;
        hit     = (c.addr < axil_pkg::addr_t'(4 * `AXIL_NUM_REGS));
        e.write = c.write;
        e.resp  = hit ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
        e.data  = (hit && !c.write) ? shadow[c.addr[5:2]] : '0;
        return e;
    endfunction

    function automatic axil_pkg::data_t merge_bytes(input axil_pkg::data_t old_word,
                                                    input axil_pkg::cmd_t  c);
        axil_pkg::data_t m;
        m = old_word;
        for (int i = 0; i < `AXIL_DATA_W / 8; i++) begin
            if (c.strb[i]) m[8*i +: 8] = c.data[8*i +: 8]; // only strobed bytes change
        end
        return m;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got === want) begin
            passes++;
        end else begin
            fails++;
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, want);
        end
    endtask

    task automatic compare_rsp();
        axil_pkg::cmd_t c;
        axil_pkg::rsp_t e;
        if (sent.size() == 0) begin
            fails++;
            $display("%0t ns: a response came out with no command waiting for it", $time);
        end else begin
            c = sent.pop_front();
            e = expected_rsp(c);
            check_field("rsp.write", 32'(rsp.write), 32'(e.write));
            check_field("rsp.resp", 32'(rsp.resp), 32'(e.resp));
            check_field("rsp.data", rsp.data, e.data);
            if (c.write && e.resp == axil_pkg::RESP_OKAY)
                shadow[c.addr[5:2]] = merge_bytes(shadow[c.addr[5:2]], c);
        end
    endtask

    // inputs move 1 ns after the rising edge, so mid-cycle shows what the next edge takes
    always @(negedge clk) begin
        if (arst_n !== 1'b1) begin
            sent.delete();
            foreach (shadow[i]) shadow[i] = '0;
            passes       = 0;
            fails        = 0;
            pending      = 0;
            idle_checked = 1'b0;
        end else begin
            if (!idle_checked) begin
                idle_checked = 1'b1;
                if (rsp_valid !== 1'b0 || cmd_ready !== 1'b1) begin
                    fails++;
                    $display("%0t ns: DUT not idle after reset, rsp_valid %b cmd_ready %b",
                             $time, rsp_valid, cmd_ready);
                end else begin
                    passes++;
                end
            end
            if (rsp_valid && rsp_ready) compare_rsp();
            if (cmd_valid && cmd_ready) sent.push_back(cmd);
            pending = sent.size();
        end
    end

endmodule

/* tb/axil_subsys_tb.sv */
`timescale 1ns/100ps
`include "axil_defs.svh"

module axil_subsys_tb;

    localparam int          NUM_RANDOM     = 300;
    // directed tests send 16 + 32 + 32 + 32 commands ahead of the two random runs
    localparam int          NUM_CMDS       = 112 + 2 * NUM_RANDOM;
    localparam int          TIMEOUT_CYCLES = NUM_CMDS * 20 + 100;
    localparam logic [31:0] SEED           = 32'h2c4b_3d80;

    logic           clk;
    logic           arst_n;
    logic           cmd_valid;
    logic           cmd_ready;
    axil_pkg::cmd_t cmd;
    logic           rsp_valid;
    logic           rsp_ready  = 1'b0;
    axil_pkg::rsp_t rsp;
    int             passes;
    int             fails;
    int             pending;
    int             fails_base = 0;
    int             cycle_cnt  = 0;
    logic           throttle   = 1'b0; // rsp_ready drops at random while set
    logic [31:0]    cmd_lfsr   = SEED;
    logic [31:0]    ready_lfsr = SEED;

    tb_clk_gen u_clk_gen (.clk, .arst_n);

    // b runs as plain wires while the other four channels go through skid buffers
    axil_subsys_top #(.BYPASS_B (1'b1)) UUT (
        .clk, .arst_n, .cmd_valid, .cmd_ready, .cmd, .rsp_valid, .rsp_ready, .rsp
    );

    axil_subsys_checker u_checker (
        .clk, .arst_n, .cmd_valid, .cmd_ready, .cmd, .rsp_valid, .rsp_ready, .rsp,
        .passes, .fails, .pending
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // takes n bits off the command stream with one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            cmd_lfsr = lfsr_step(cmd_lfsr);
            v        = {v[30:0], cmd_lfsr[0]};
        end
        return v;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic issue(input axil_pkg::cmd_t c);
        logic taken;
        cmd       = c;
        cmd_valid = 1'b1;
        taken     = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = cmd_ready; // cmd_ready comes from a register and holds until the edge
            @(posedge clk);
        end
        #1;
        cmd_valid = 1'b0;
    endtask

    // one command to every word of the bank
    task automatic sweep(input logic wr, input logic part_strb);
        logic [31:0] d;
        logic [31:0] s;
        for (int i = 0; i < `AXIL_NUM_REGS; i++) begin
            d = '0;
            s = 32'hf;
            if (wr) d = rand_bits(32);
            if (part_strb) s = rand_bits(4);
            issue('{write: wr, addr: 32'(4 * i), data: d, strb: s[3:0]});
        end
    endtask

    task automatic random_run(input logic gaps);
        logic [31:0]    r;
        logic           oor;
        axil_pkg::cmd_t c;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            if (gaps) begin
                r = rand_bits(2);
                idle_cycles(int'(r[1:0]));
            end
            r       = rand_bits(1);
            c.write = r[0];
            r       = rand_bits(2);
            oor     = (r[1:0] == 2'b11); // about one in four lands past the bank
            r       = oor ? rand_bits(24) : rand_bits(4);
            c.addr  = oor ? (32'h40 | {6'b0, r[23:0], 2'b00}) : {26'b0, r[3:0], 2'b00};
            c.data  = rand_bits(32);
            r       = rand_bits(4);
            c.strb  = r[3:0];
            issue(c);
        end
    endtask

    task automatic finish_test(input string name);
        @(posedge clk);
        while (pending != 0) @(posedge clk);
        $display("%-20s done, %0d failures", name, fails - fails_base);
        fails_base = fails;
        #1;
    endtask

    always begin
        @(posedge clk);
        #1;
        if (throttle) begin
            ready_lfsr = lfsr_step(ready_lfsr);
            rsp_ready  = ready_lfsr[0];
        end else begin
            rsp_ready = 1'b1;
        end
    end

    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        logic [31:0] a;
        logic [31:0] d;
        cmd_valid = 1'b0;
        cmd       = '0;
        wait (arst_n === 1'b1);
        idle_cycles(2);

        sweep(1'b0, 1'b0);
        finish_test("reset values");

        sweep(1'b1, 1'b0);
        sweep(1'b0, 1'b0);
        finish_test("full strobe writes");

        sweep(1'b1, 1'b1);
        sweep(1'b0, 1'b0);
        finish_test("partial strobes");

        for (int i = 0; i < 8; i++) begin
            a = 32'h40 + 32'(i) * 32'h2000_0004; // 0x40 first and then far above the bank
            d = rand_bits(32);
            issue('{write: 1'b1, addr: a, data: d, strb: 4'hf});
            issue('{write: 1'b0, addr: a, data: '0, strb: '0});
        end
        sweep(1'b0, 1'b0);
        finish_test("out of range");

        throttle = 1'b1;
        random_run(1'b0);
        finish_test("random commands");
        random_run(1'b1);
        finish_test("random with gaps");

        $display("%0d checks passed, %0d checks failed", passes, fails);
        if (fails == 0 && passes > 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

/* tb/tb_clk_gen.sv */
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int HALF_PERIOD  = 2,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // reset lets go 1 ns after an edge, like the rest of the stimulus
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 arst_n = 1'b1;
    end

endmodule
